//--- logic/adder_pkg.sv
package adder_pkg;

  // full datapath width
  localparam int WORD_W = 64;

  // width of one lookahead slice, fixed by its carry pattern
  localparam int SLICE_W = 8;

  // slices chained to build the full word
  localparam int NUM_SLICES = WORD_W / SLICE_W;

  // operands and sums of the whole adder
  typedef logic [WORD_W-1:0] word_t;

  // slice operands, sums and bit propagates
  typedef logic [SLICE_W-1:0] slice_t;

  // one term per adjacent bit pair inside a slice
  typedef logic [SLICE_W-2:0] pair_t;

endpackage

//--- logic/pg_gen.sv
`timescale 1ns/1ps

module pg_gen (
  input  adder_pkg::slice_t a,
  input  adder_pkg::slice_t b,
  output adder_pkg::slice_t p,
  output logic              g0,
  output adder_pkg::pair_t  pp,
  output adder_pkg::pair_t  pg
);

  import adder_pkg::*;

  // bit generate, only bit 0 leaves the module directly
  slice_t g;

  genvar i;

  // per-bit propagate and generate
  generate
    for (i = 0; i < SLICE_W; i++) begin : g_bit
      assign p[i] = a[i] ^ b[i];
      assign g[i] = a[i] & b[i];
    end
  endgenerate

  assign g0 = g[0];

  // pair terms over bits i and i+1
  // lets each carry skip back two positions in one and-or
  generate
    for (i = 0; i < SLICE_W - 1; i++) begin : g_pair
      assign pp[i] = p[i+1] & p[i];
      assign pg[i] = g[i+1] | (p[i+1] & g[i]);
    end
  endgenerate

endmodule

//--- logic/ks_slice.sv
`timescale 1ns/1ps

module ks_slice (
  input  adder_pkg::slice_t a,
  input  adder_pkg::slice_t b,
  input  logic              cin,
  output adder_pkg::slice_t sum,
  output logic              cout
);

  import adder_pkg::*;

  // terms from the propagate/generate block
  slice_t p;
  logic   g0;
  pair_t  pp;
  pair_t  pg;

  // carry into each bit position
  slice_t c_in;

  // carry out of each bit position
  slice_t c_out;

  genvar i;

  pg_gen pg_gen_i (
    .a  (a),
    .b  (b),
    .p  (p),
    .g0 (g0),
    .pp (pp),
    .pg (pg)
  );

  // bit 0 only sees the slice carry
  assign c_in[0]  = cin;
  assign c_out[0] = g0 | (p[0] & cin);

  // each higher carry combines a pair term with the carry two bits back
  // i = 0 therefore reaches straight to cin
  generate
    for (i = 0; i < SLICE_W - 1; i++) begin : g_carry
      assign c_out[i+1] = pg[i] | (pp[i] & c_in[i]);
    end
  endgenerate

  // carry into bit i is the carry out of bit i-1
  generate
    for (i = 1; i < SLICE_W; i++) begin : g_cin
      assign c_in[i] = c_out[i-1];
    end
  endgenerate

  // sum bits
  generate
    for (i = 0; i < SLICE_W; i++) begin : g_sum
      assign sum[i] = p[i] ^ c_in[i];
    end
  endgenerate

  assign cout = c_out[SLICE_W-1];

endmodule

//--- logic/ks_adder_64.sv
`timescale 1ns/1ps

module ks_adder_64 (
  input  adder_pkg::word_t a,
  input  adder_pkg::word_t b,
  input  logic             cin,
  output adder_pkg::word_t sum,
  output logic             cout
);

  import adder_pkg::*;

  // carry[k] enters slice k, carry[NUM_SLICES] leaves the top slice
  logic [NUM_SLICES:0] carry;

  genvar k;

  assign carry[0] = cin;

  // byte lanes, carry ripples lane to lane
  generate
    for (k = 0; k < NUM_SLICES; k++) begin : g_slice
      ks_slice slice_i (
        .a    (a[k*SLICE_W +: SLICE_W]),
        .b    (b[k*SLICE_W +: SLICE_W]),
        .cin  (carry[k]),
        .sum  (sum[k*SLICE_W +: SLICE_W]),
        .cout (carry[k+1])
      );
    end
  endgenerate

  assign cout = carry[NUM_SLICES];

endmodule

//--- logic/addsub_top.sv
`timescale 1ns/1ps

module addsub_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  input  logic             sub,
  input  adder_pkg::word_t a,
  input  adder_pkg::word_t b,
  input  logic             cin,
  output logic             out_valid,
  output adder_pkg::word_t sum,
  output logic             carry,
  output logic             overflow,
  output logic             zero,
  output logic             negative
);

  import adder_pkg::*;

  // second operand after the operation select
  word_t b_eff;

  // stage 1
  logic  s1_valid;
  word_t s1_a;
  word_t s1_b;
  logic  s1_cin;

  // adder result
  word_t add_sum;
  logic  add_cout;

  // sign bits and next flag values
  logic  a_sign;
  logic  b_sign;
  logic  sum_sign;
  logic  overflow_next;
  logic  zero_next;

  // subtract is a + ~b + cin, cin set means no borrow
  assign b_eff = sub ? ~b : b;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  // operands only load on an accepted vector
  always_ff @(posedge clk) begin
    if (in_valid) begin
      s1_a   <= a;
      s1_b   <= b_eff;
      s1_cin <= cin;
    end
  end

  ks_adder_64 adder_i (
    .a    (s1_a),
    .b    (s1_b),
    .cin  (s1_cin),
    .sum  (add_sum),
    .cout (add_cout)
  );

  assign a_sign   = s1_a[WORD_W-1];
  assign b_sign   = s1_b[WORD_W-1];
  assign sum_sign = add_sum[WORD_W-1];

  // signed overflow: operands agree in sign, result does not
  assign overflow_next = (a_sign == b_sign) && (sum_sign != a_sign);
  assign zero_next     = (add_sum == '0);

  // stage 2, results hold through idle cycles
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      sum       <= '0;
      carry     <= 1'b0;
      overflow  <= 1'b0;
      zero      <= 1'b0;
      negative  <= 1'b0;
    end else begin
      out_valid <= s1_valid;
      if (s1_valid) begin
        sum      <= add_sum;
        carry    <= add_cout;
        overflow <= overflow_next;
        zero     <= zero_next;
        negative <= sum_sign;
      end
    end
  end

endmodule

//--- verification/addsub_tb.sv
`timescale 1ns/1ps

module addsub_tb;

  import adder_pkg::*;

  localparam int NUM_DIRECTED = 89;
  localparam int NUM_FIELDS   = 9;
  localparam int NUM_RANDOM   = 200;
  localparam int RST_CYCLES   = 3;
  localparam int PHASE_GAP    = 3;

  // one idle cycle per 8 directed vectors and two per 10 random vectors
  localparam int IDLE_CYCLES = NUM_DIRECTED / 8 + PHASE_GAP + 2 * (NUM_RANDOM / 10);
  localparam int MAX_CYCLES  = RST_CYCLES + NUM_DIRECTED + NUM_RANDOM + IDLE_CYCLES + 50;

  logic  clk;
  logic  rst;
  logic  in_valid;
  logic  sub;
  word_t a;
  word_t b;
  logic  cin;
  logic  out_valid;
  word_t sum;
  logic  carry;
  logic  overflow;
  logic  zero;
  logic  negative;

  // nine fields per vector as laid out in the pattern file header
  word_t patterns [0:NUM_DIRECTED*NUM_FIELDS-1];

  // in-flight vectors with flags packed as {carry, overflow, zero, negative}
  word_t      exp_sum_q[$];
  logic [3:0] exp_flags_q[$];
  int         id_q[$];
  int         due_q[$];

  // negedge count for the latency check and the timeout
  int cyc = 0;

  // last expected result, held through idle cycles
  word_t      last_sum   = '0;
  logic [3:0] last_flags = '0;

  initial clk = 1'b0;
  always #5 clk = ~clk;

  addsub_top dut_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .sub       (sub),
    .a         (a),
    .b         (b),
    .cin       (cin),
    .out_valid (out_valid),
    .sum       (sum),
    .carry     (carry),
    .overflow  (overflow),
    .zero      (zero),
    .negative  (negative)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input string field,
                             input word_t expected, input word_t actual);
    assert (actual === expected) else begin
      fail_run($sformatf("ERR %s %s: expected %0h, actual %0h",
                         name, field, expected, actual));
    end
  endtask

  function automatic string test_name(input int id);
    if (id < NUM_DIRECTED) begin
      return $sformatf("directed_%0d", id);
    end
    return $sformatf("random_%0d", id - NUM_DIRECTED);
  endfunction

  // 65-bit reference where add is x + y + c and subtract is x + ~y + c
  task automatic model(input logic op_sub, input logic c_in, input word_t x, input word_t y,
                       output word_t exp_sum, output logic [3:0] exp_flags);
    logic [WORD_W:0] full;
    word_t           y_eff;
    logic            ovf;
    y_eff     = op_sub ? ~y : y;
    full      = {1'b0, x} + {1'b0, y_eff} + c_in;
    ovf       = (x[WORD_W-1] == y_eff[WORD_W-1]) && (full[WORD_W-1] != x[WORD_W-1]);
    exp_sum   = full[WORD_W-1:0];
    exp_flags = {full[WORD_W], ovf, full[WORD_W-1:0] == '0, full[WORD_W-1]};
  endtask

  task automatic apply_vector(input int id, input logic op_sub, input logic c_in,
                              input word_t x, input word_t y,
                              input word_t exp_sum, input logic [3:0] exp_flags);
    @(posedge clk);
    in_valid <= 1'b1;
    sub      <= op_sub;
    cin      <= c_in;
    a        <= x;
    b        <= y;
    exp_sum_q.push_back(exp_sum);
    exp_flags_q.push_back(exp_flags);
    id_q.push_back(id);
    due_q.push_back(cyc + 2);
  endtask

  // junk on the operands that must not be captured
  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      in_valid <= 1'b0;
      sub      <= ~sub;
      a        <= ~a;
      b        <= {b[0], b[WORD_W-1:1]};
    end
  endtask

  always @(negedge clk) begin
    string      name;
    int         id;
    word_t      exp_sum;
    logic [3:0] exp_flags;
    logic [3:0] act_flags;
    if (cyc > MAX_CYCLES) begin
      fail_run($sformatf("timeout: results still pending after %0d cycles", cyc));
    end
    act_flags = {carry, overflow, zero, negative};
    if (!rst) begin
      if (due_q.size() != 0 && due_q[0] == cyc) begin
        void'(due_q.pop_front());
        id        = id_q.pop_front();
        exp_sum   = exp_sum_q.pop_front();
        exp_flags = exp_flags_q.pop_front();
        name      = test_name(id);
        check_value(name, "out_valid", 1, out_valid);
        check_value(name, "sum", exp_sum, sum);
        check_value(name, "carry", exp_flags[3], carry);
        check_value(name, "overflow", exp_flags[2], overflow);
        check_value(name, "zero", exp_flags[1], zero);
        check_value(name, "negative", exp_flags[0], negative);
        last_sum   = exp_sum;
        last_flags = exp_flags;
      end else begin
        name = $sformatf("idle_cycle_%0d", cyc);
        check_value(name, "out_valid", 0, out_valid);
        check_value(name, "held sum", last_sum, sum);
        check_value(name, "held flags", last_flags, act_flags);
      end
    end
    cyc = cyc + 1;
  end

  initial begin
    word_t      x;
    word_t      y;
    word_t      exp_sum;
    logic [3:0] exp_flags;
    logic       op_sub;
    logic       c_in;
    int         base;
    void'($urandom(67));
    rst      = 1'b1;
    in_valid = 1'b0;
    sub      = 1'b0;
    a        = '0;
    b        = '0;
    cin      = 1'b0;

    $readmemh("verification/addsub_patterns.mem", patterns);
    assert (!$isunknown(patterns[NUM_DIRECTED*NUM_FIELDS-1])) else begin
      fail_run("pattern file holds fewer vectors than expected");
    end

    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;

    @(negedge clk);
    check_value("reset", "out_valid", 0, out_valid);
    check_value("reset", "sum", 0, sum);
    check_value("reset", "flags", 0, {carry, overflow, zero, negative});

    // directed corner cases back to back with a short gap now and then
    for (int i = 0; i < NUM_DIRECTED; i++) begin
      base      = i * NUM_FIELDS;
      exp_flags = {patterns[base+5][0], patterns[base+6][0],
                   patterns[base+7][0], patterns[base+8][0]};
      apply_vector(i, patterns[base][0], patterns[base+1][0], patterns[base+2],
                   patterns[base+3], patterns[base+4], exp_flags);
      if (i % 8 == 7) begin
        idle(1);
      end
    end

    idle(PHASE_GAP);

    for (int i = 0; i < NUM_RANDOM; i++) begin
      op_sub   = $urandom % 2;
      c_in     = $urandom % 2;
      x[31:0]  = $urandom;
      x[63:32] = $urandom;
      y[31:0]  = $urandom;
      y[63:32] = $urandom;
      // equal operands now and then so subtract hits zero
      if ($urandom % 8 == 0) begin
        y = x;
      end
      model(op_sub, c_in, x, y, exp_sum, exp_flags);
      apply_vector(NUM_DIRECTED + i, op_sub, c_in, x, y, exp_sum, exp_flags);
      if (i % 10 == 9) begin
        idle(2);
      end
    end

    idle(1);
    while (due_q.size() != 0) begin
      @(posedge clk);
    end
    // a few quiet cycles with no stray out_valid allowed
    repeat (4) @(posedge clk);
    $display("TEST PASS");
    $finish;
  end

endmodule

//--- all.f
logic/adder_pkg.sv
logic/pg_gen.sv
logic/ks_slice.sv
logic/ks_adder_64.sv
logic/addsub_top.sv
verification/addsub_tb.sv

//--- verification/addsub_patterns.mem
// columns: sub cin a b sum carry overflow zero negative
// all fields hex, one vector per line
// add, zeros and cin alone
0 0 0000000000000000 0000000000000000 0000000000000000 0 0 1 0
0 1 0000000000000000 0000000000000000 0000000000000001 0 0 0 0
0 1 0000000000000005 0000000000000000 0000000000000006 0 0 0 0
0 0 0000000000000003 0000000000000004 0000000000000007 0 0 0 0
0 0 FFFFFFFFFFFFFFFF 0000000000000001 0000000000000000 1 0 1 0
0 1 FFFFFFFFFFFFFFFF 0000000000000000 0000000000000000 1 0 1 0
0 0 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFE 1 0 0 1
0 1 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 1 0 0 1
// carry ripples over each slice boundary, b = 1
0 0 00000000000000FF 0000000000000001 0000000000000100 0 0 0 0
0 0 000000000000FFFF 0000000000000001 0000000000010000 0 0 0 0
0 0 0000000000FFFFFF 0000000000000001 0000000001000000 0 0 0 0
0 0 00000000FFFFFFFF 0000000000000001 0000000100000000 0 0 0 0
0 0 000000FFFFFFFFFF 0000000000000001 0000010000000000 0 0 0 0
0 0 0000FFFFFFFFFFFF 0000000000000001 0001000000000000 0 0 0 0
0 0 00FFFFFFFFFFFFFF 0000000000000001 0100000000000000 0 0 0 0
// same ripple started by cin
0 1 00000000000000FF 0000000000000000 0000000000000100 0 0 0 0
0 1 000000000000FFFF 0000000000000000 0000000000010000 0 0 0 0
0 1 0000000000FFFFFF 0000000000000000 0000000001000000 0 0 0 0
0 1 00000000FFFFFFFF 0000000000000000 0000000100000000 0 0 0 0
0 1 000000FFFFFFFFFF 0000000000000000 0000010000000000 0 0 0 0
0 1 0000FFFFFFFFFFFF 0000000000000000 0001000000000000 0 0 0 0
0 1 00FFFFFFFFFFFFFF 0000000000000000 0100000000000000 0 0 0 0
// all ones plus the low bit of each slice, carry runs out the top
0 0 FFFFFFFFFFFFFFFF 0000000000000100 00000000000000FF 1 0 0 0
0 0 FFFFFFFFFFFFFFFF 0000000000010000 000000000000FFFF 1 0 0 0
0 0 FFFFFFFFFFFFFFFF 0000000001000000 0000000000FFFFFF 1 0 0 0
0 0 FFFFFFFFFFFFFFFF 0000000100000000 00000000FFFFFFFF 1 0 0 0
0 0 FFFFFFFFFFFFFFFF 0000010000000000 000000FFFFFFFFFF 1 0 0 0
0 0 FFFFFFFFFFFFFFFF 0001000000000000 0000FFFFFFFFFFFF 1 0 0 0
0 0 FFFFFFFFFFFFFFFF 0100000000000000 00FFFFFFFFFFFFFF 1 0 0 0
// generate in the top bit of each slice
0 0 0000000000000080 0000000000000080 0000000000000100 0 0 0 0
0 0 0000000000008000 0000000000008000 0000000000010000 0 0 0 0
0 0 0000000000800000 0000000000800000 0000000001000000 0 0 0 0
0 0 0000000080000000 0000000080000000 0000000100000000 0 0 0 0
0 0 0000008000000000 0000008000000000 0000010000000000 0 0 0 0
0 0 0000800000000000 0000800000000000 0001000000000000 0 0 0 0
0 0 0080000000000000 0080000000000000 0100000000000000 0 0 0 0
// mixed bit patterns
0 0 00FF00FF00FF00FF 0001000100010001 0100010001000100 0 0 0 0
0 0 FF00FF00FF00FF00 0100010001000100 0001000100010000 1 0 0 0
0 0 5555555555555555 AAAAAAAAAAAAAAAA FFFFFFFFFFFFFFFF 0 0 0 1
0 1 5555555555555555 AAAAAAAAAAAAAAAA 0000000000000000 1 0 1 0
0 0 0123456789ABCDEF FEDCBA9876543210 FFFFFFFFFFFFFFFF 0 0 0 1
0 1 0123456789ABCDEF FEDCBA9876543210 0000000000000000 1 0 1 0
0 0 1111111111111111 2222222222222222 3333333333333333 0 0 0 0
0 1 0F0F0F0F0F0F0F0F 00F000F000F000F0 0FFF0FFF0FFF1000 0 0 0 0
// subtract, equal operands give zero with no borrow
1 1 0000000000000000 0000000000000000 0000000000000000 1 0 1 0
1 1 0000000000000001 0000000000000001 0000000000000000 1 0 1 0
1 1 123456789ABCDEF0 123456789ABCDEF0 0000000000000000 1 0 1 0
1 1 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 0000000000000000 1 0 1 0
1 1 7FFFFFFFFFFFFFFF 7FFFFFFFFFFFFFFF 0000000000000000 1 0 1 0
1 1 8000000000000000 8000000000000000 0000000000000000 1 0 1 0
// subtract, a below b unsigned, borrow out
1 1 0000000000000001 0000000000000002 FFFFFFFFFFFFFFFF 0 0 0 1
1 1 0000000000000000 0000000000000001 FFFFFFFFFFFFFFFF 0 0 0 1
1 1 0000000000000100 0000000000000200 FFFFFFFFFFFFFF00 0 0 0 1
1 1 0000000000001000 00000000000FFFFF FFFFFFFFFFF01001 0 0 0 1
1 1 0000000000000000 FFFFFFFFFFFFFFFF 0000000000000001 0 0 0 0
// subtract, a at or above b, borrow chains through slices
1 1 0000000000000005 0000000000000003 0000000000000002 1 0 0 0
1 1 0000000000000100 0000000000000001 00000000000000FF 1 0 0 0
1 1 0000000000010000 0000000000000001 000000000000FFFF 1 0 0 0
1 1 0000000001000000 0000000000000001 0000000000FFFFFF 1 0 0 0
1 1 0000000100000000 0000000000000001 00000000FFFFFFFF 1 0 0 0
1 1 0000010000000000 0000000000000001 000000FFFFFFFFFF 1 0 0 0
1 1 0001000000000000 0000000000000001 0000FFFFFFFFFFFF 1 0 0 0
1 1 0100000000000000 0000000000000001 00FFFFFFFFFFFFFF 1 0 0 0
1 1 FEDCBA9876543210 0123456789ABCDEF FDB97530ECA86421 1 0 0 1
// subtract with a borrow in, cin clear
1 0 0000000000000005 0000000000000003 0000000000000001 1 0 0 0
1 0 0000000000000003 0000000000000003 FFFFFFFFFFFFFFFF 0 0 0 1
1 0 0000000000000000 0000000000000000 FFFFFFFFFFFFFFFF 0 0 0 1
1 0 0000000000000001 0000000000000000 0000000000000000 1 0 1 0
// signed overflow, both directions
0 0 7FFFFFFFFFFFFFFF 0000000000000001 8000000000000000 0 1 0 1
0 1 7FFFFFFFFFFFFFFF 0000000000000000 8000000000000000 0 1 0 1
0 0 7FFFFFFFFFFFFFFF 7FFFFFFFFFFFFFFF FFFFFFFFFFFFFFFE 0 1 0 1
0 0 4000000000000000 4000000000000000 8000000000000000 0 1 0 1
0 0 8000000000000000 8000000000000000 0000000000000000 1 1 1 0
0 0 8000000000000000 FFFFFFFFFFFFFFFF 7FFFFFFFFFFFFFFF 1 1 0 0
0 0 AAAAAAAAAAAAAAAA AAAAAAAAAAAAAAAA 5555555555555554 1 1 0 0
0 0 5555555555555555 5555555555555555 AAAAAAAAAAAAAAAA 0 1 0 1
0 0 8888888888888888 8888888888888888 1111111111111110 1 1 0 0
1 1 8000000000000000 0000000000000001 7FFFFFFFFFFFFFFF 1 1 0 0
1 1 7FFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 8000000000000000 0 1 0 1
1 1 0000000000000000 8000000000000000 8000000000000000 0 1 0 1
1 0 8000000000000000 0000000000000000 7FFFFFFFFFFFFFFF 1 1 0 0
// operand signs differ, never an overflow
0 0 7FFFFFFFFFFFFFFF 8000000000000000 FFFFFFFFFFFFFFFF 0 0 0 1
0 1 7FFFFFFFFFFFFFFF 8000000000000000 0000000000000000 1 0 1 0
0 0 7FFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 7FFFFFFFFFFFFFFE 1 0 0 0
0 0 8000000000000000 0000000000000001 8000000000000001 0 0 0 1
0 0 0000000000000001 FFFFFFFFFFFFFFFF 0000000000000000 1 0 1 0
1 1 8000000000000000 FFFFFFFFFFFFFFFF 8000000000000001 0 0 0 1
1 1 7FFFFFFFFFFFFFFF 0000000000000001 7FFFFFFFFFFFFFFE 1 0 0 0
1 1 C000000000000000 8000000000000000 4000000000000000 1 0 0 0
